// ==== Makefile ====
# Verilator build and run of the asynchronous FIFO testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_cdc_fifo
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

# the simulator exits non-zero when the testbench stops with a failure
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== cdc_fifo.sv ====
`timescale 1ns/1ps

module cdc_fifo (
  // write domain
  input  logic                      w_clk,
  input  logic                      w_rst_n,
  input  logic                      w_inc,
  input  fifo_data_pkg::data_t      w_data,
  output fifo_data_pkg::w_status_t  w_status,

  // read domain
  input  logic                      r_clk,
  input  logic                      r_rst_n,
  input  logic                      r_inc,
  output fifo_data_pkg::data_t      r_data,
  output fifo_data_pkg::r_status_t  r_status
);

  // memory addresses from both pointer blocks
  fifo_ptr_pkg::addr_t w_addr;
  fifo_ptr_pkg::addr_t r_addr;

  // Gray pointers in their own domains
  fifo_ptr_pkg::ptr_t w_ptr;
  fifo_ptr_pkg::ptr_t r_ptr;

  // Gray pointers after crossing into the other domain
  fifo_ptr_pkg::ptr_t r_q2_wptr;
  fifo_ptr_pkg::ptr_t w_q2_rptr;

  // a write lands in memory only when it is accepted
  logic w_en;

  assign w_en = w_inc & ~w_status.full;

  cdc_fifo_mem u_mem (
    .w_clk  (w_clk),
    .w_en   (w_en),
    .w_addr (w_addr),
    .w_data (w_data),
    .r_addr (r_addr),
    .r_data (r_data)
  );

  // the read pointer is brought into the write domain for full
  cdc_sync2 u_sync_r2w (
    .clk   (w_clk),
    .rst_n (w_rst_n),
    .d     (r_ptr),
    .q     (w_q2_rptr)
  );

  // and the write pointer into the read domain for empty
  cdc_sync2 u_sync_w2r (
    .clk   (r_clk),
    .rst_n (r_rst_n),
    .d     (w_ptr),
    .q     (r_q2_wptr)
  );

  cdc_fifo_wptr_full u_wptr_full (
    .w_clk     (w_clk),
    .w_rst_n   (w_rst_n),
    .w_inc     (w_inc),
    .w_q2_rptr (w_q2_rptr),
    .w_status  (w_status),
    .w_ptr     (w_ptr),
    .w_addr    (w_addr)
  );

  cdc_fifo_rptr_empty u_rptr_empty (
    .r_clk     (r_clk),
    .r_rst_n   (r_rst_n),
    .r_inc     (r_inc),
    .r_q2_wptr (r_q2_wptr),
    .r_status  (r_status),
    .r_ptr     (r_ptr),
    .r_addr    (r_addr)
  );

endmodule

// ==== cdc_fifo_mem.sv ====
`timescale 1ns/1ps
`include "fifo_defs.svh"

module cdc_fifo_mem (
  input  logic                 w_clk,
  input  logic                 w_en,
  input  fifo_ptr_pkg::addr_t  w_addr,
  input  fifo_data_pkg::data_t w_data,
  input  fifo_ptr_pkg::addr_t  r_addr,
  output fifo_data_pkg::data_t r_data
);

  // one entry per address value
  localparam int unsigned depth = 1 << `FIFO_ADDR_SIZE;

  // storage shared by both clock domains
  fifo_data_pkg::data_t mem [depth];

  // the write side owns the array and updates it on w_clk only
  // the enable already excludes writes into a full FIFO
  always_ff @(posedge w_clk) begin
    if (w_en) begin
      mem[w_addr] <= w_data;
    end
  end

  // the read port has no clock of its own
  // the head word shows on r_data as soon as the read address points at it,
  // which gives the first-word-fall-through behaviour
  // the read side only looks here while empty is low, and the
  // synchronizer delay on the write pointer ensures the entry has settled
  assign r_data = mem[r_addr];

endmodule

// ==== cdc_fifo_rptr_empty.sv ====
`timescale 1ns/1ps
`include "fifo_defs.svh"

module cdc_fifo_rptr_empty (
  input  logic                      r_clk,
  input  logic                      r_rst_n,
  input  logic                      r_inc,
  input  fifo_ptr_pkg::ptr_t        r_q2_wptr,
  output fifo_data_pkg::r_status_t  r_status,
  output fifo_ptr_pkg::ptr_t        r_ptr,
  output fifo_ptr_pkg::addr_t       r_addr
);

  // used-slot count at or below which almost-empty rises
  localparam fifo_ptr_pkg::ptr_t almost_empty_slots =
    fifo_ptr_pkg::ptr_t'(`FIFO_ALMOST_EMPTY_BUF);

  // binary copy of the read pointer, local to the read domain
  fifo_ptr_pkg::ptr_t r_bin;

  // pointer values after the current edge
  fifo_ptr_pkg::ptr_t r_bin_next;
  fifo_ptr_pkg::ptr_t r_gray_next;

  // write pointer as seen here, decoded for the slot count
  fifo_ptr_pkg::ptr_t r_w_bin;

  // words still stored once the current read is done
  fifo_ptr_pkg::ptr_t r_used_next;

  // flag values to be registered
  logic r_empty_val;
  logic r_almost_empty_val;

  // the head word sits at the low bits of the binary pointer
  assign r_addr = r_bin[`FIFO_ADDR_SIZE-1:0];

  // a read while empty is ignored and the head stays where it is
  assign r_bin_next  = r_bin + fifo_ptr_pkg::ptr_t'(r_inc & ~r_status.empty);
  assign r_gray_next = fifo_ptr_pkg::bin_to_gray(r_bin_next);

  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      r_bin <= '0;
      r_ptr <= '0;
    end else begin
      r_bin <= r_bin_next;
      r_ptr <= r_gray_next;
    end
  end

  // empty when both pointers match, wrap bit included
  // checked on the next value so the last read raises empty at its own edge
  assign r_empty_val = (r_gray_next == r_q2_wptr);

  // the synchronized write pointer lags by two or three edges
  // so the count may be low but is never high
  assign r_w_bin            = fifo_ptr_pkg::gray_to_bin(r_q2_wptr);
  assign r_used_next        = r_w_bin - r_bin_next;
  assign r_almost_empty_val = (r_used_next <= almost_empty_slots);

  // after reset nothing is stored, so both flags start high
  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      r_status.empty        <= 1'b1;
      r_status.almost_empty <= 1'b1;
    end else begin
      r_status.empty        <= r_empty_val;
      r_status.almost_empty <= r_almost_empty_val;
    end
  end

  // once the registered pointers meet, nothing is left to read, so the
  // next edge must leave the pointer sent to the write domain unchanged
  a_no_advance_when_empty: assert property (
    @(posedge r_clk) disable iff (!r_rst_n)
    (r_ptr == r_q2_wptr) |=> $stable(r_ptr)
  );

endmodule

// ==== cdc_fifo_wptr_full.sv ====
`timescale 1ns/1ps
`include "fifo_defs.svh"

module cdc_fifo_wptr_full (
  input  logic                      w_clk,
  input  logic                      w_rst_n,
  input  logic                      w_inc,
  input  fifo_ptr_pkg::ptr_t        w_q2_rptr,
  output fifo_data_pkg::w_status_t  w_status,
  output fifo_ptr_pkg::ptr_t        w_ptr,
  output fifo_ptr_pkg::addr_t       w_addr
);

  // used-slot count at which almost-full rises
  localparam fifo_ptr_pkg::ptr_t almost_full_slots =
    fifo_ptr_pkg::ptr_t'((1 << `FIFO_ADDR_SIZE) - `FIFO_ALMOST_FULL_BUF);

  // used-slot count of a completely full FIFO
  localparam fifo_ptr_pkg::ptr_t depth_slots =
    fifo_ptr_pkg::ptr_t'(1 << `FIFO_ADDR_SIZE);

  // a full FIFO has the write pointer one lap ahead of the read pointer
  // in Gray code that lap inverts the two top bits and keeps the rest
  localparam fifo_ptr_pkg::ptr_t full_mask =
    fifo_ptr_pkg::ptr_t'(3 << (`FIFO_ADDR_SIZE - 1));

  // binary copy of the write pointer, only ever used inside this domain
  fifo_ptr_pkg::ptr_t w_bin;

  // pointer values after the current edge
  fifo_ptr_pkg::ptr_t w_bin_next;
  fifo_ptr_pkg::ptr_t w_gray_next;

  // read pointer decoded to binary for the slot count
  fifo_ptr_pkg::ptr_t w_r_bin;

  // slots in use once the current write has landed
  fifo_ptr_pkg::ptr_t w_used_next;

  // flag values to be registered
  logic w_full_val;
  logic w_almost_full_val;

  // the memory may be addressed in binary, only the crossing needs Gray
  assign w_addr = w_bin[`FIFO_ADDR_SIZE-1:0];

  // a write while full is dropped here, so the pointer stays put
  assign w_bin_next  = w_bin + fifo_ptr_pkg::ptr_t'(w_inc & ~w_status.full);
  assign w_gray_next = fifo_ptr_pkg::bin_to_gray(w_bin_next);

  always_ff @(posedge w_clk) begin
    if (!w_rst_n) begin
      w_bin <= '0;
      w_ptr <= '0;
    end else begin
      w_bin <= w_bin_next;
      w_ptr <= w_gray_next;
    end
  end

  // full compares Gray codes directly, so no decode sits on this path
  assign w_full_val = (w_gray_next == (w_q2_rptr ^ full_mask));

  // a range check does not work on Gray codes, so the read pointer is decoded
  // the count uses the next write pointer so both flags rise on the same edge
  assign w_r_bin           = fifo_ptr_pkg::gray_to_bin(w_q2_rptr);
  assign w_used_next       = w_bin_next - w_r_bin;
  assign w_almost_full_val = (w_used_next >= almost_full_slots);

  // the read pointer seen here lags, so both flags are pessimistic
  // and release only once the freed space has crossed over
  always_ff @(posedge w_clk) begin
    if (!w_rst_n) begin
      w_status.full        <= 1'b0;
      w_status.almost_full <= 1'b0;
    end else begin
      w_status.full        <= w_full_val;
      w_status.almost_full <= w_almost_full_val;
    end
  end

  // once the pointers show every slot in use, the next edge must not move
  // the Gray pointer that goes to the read domain, whatever w_inc does
  a_no_advance_when_full: assert property (
    @(posedge w_clk) disable iff (!w_rst_n)
    (fifo_ptr_pkg::ptr_t'(fifo_ptr_pkg::gray_to_bin(w_ptr) - w_r_bin) == depth_slots)
      |=> $stable(w_ptr)
  );

endmodule

// ==== cdc_sync2.sv ====
`timescale 1ns/1ps
`include "fifo_defs.svh"

module cdc_sync2 (
  input  logic               clk,
  input  logic               rst_n,
  input  fifo_ptr_pkg::ptr_t d,
  output fifo_ptr_pkg::ptr_t q
);

  // the first stage may go metastable, the second gives it a full cycle to settle
  fifo_ptr_pkg::ptr_t q1;

  // a forward jump larger than the whole array would mean a lost Gray step
  localparam fifo_ptr_pkg::ptr_t max_step = fifo_ptr_pkg::ptr_t'(1 << `FIFO_ADDR_SIZE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q1 <= '0;
      q  <= '0;
    end else begin
      q1 <= d;
      q  <= q1;
    end
  end

  // the source counts forward only, so the decoded value seen here never
  // steps back and never skips more than one depth between two samples
  a_forward_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    fifo_ptr_pkg::ptr_t'(fifo_ptr_pkg::gray_to_bin(q) -
                         fifo_ptr_pkg::gray_to_bin($past(q))) <= max_step
  );

endmodule

// ==== fifo_data_pkg.sv ====
`include "fifo_defs.svh"

package fifo_data_pkg;

  // one word as it is stored and returned
  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

  // flags of the write domain, registered on w_clk
  typedef struct packed {
    // no room left, further writes are ignored
    logic full;
    // few slots left, lets a producer stop early
    logic almost_full;
  } w_status_t;

  // flags of the read domain, registered on r_clk
  typedef struct packed {
    // nothing stored, the word on r_data is stale
    logic empty;
    // only a few words left to read
    logic almost_empty;
  } r_status_t;

endpackage

// ==== fifo_defs.svh ====
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// number of address bits into the storage array
// the FIFO holds two to this power words, so 4 gives a depth of 16
`define FIFO_ADDR_SIZE 4

// width of one stored data word
`define FIFO_DATA_WIDTH 8

// almost-full rises once the free slots drop to this count or fewer
`define FIFO_ALMOST_FULL_BUF 1

// almost-empty rises once the used slots drop to this count or fewer
// a value of zero makes it follow empty exactly
`define FIFO_ALMOST_EMPTY_BUF 1

`endif

// ==== fifo_ptr_pkg.sv ====
`include "fifo_defs.svh"

package fifo_ptr_pkg;

  // a pointer carries one wrap bit above the address bits
  // the wrap bit tells a full FIFO apart from an empty one
  typedef logic [`FIFO_ADDR_SIZE:0] ptr_t;

  // address into the storage array, the pointer without its wrap bit
  typedef logic [`FIFO_ADDR_SIZE-1:0] addr_t;

  // neighbouring binary values map to Gray codes that differ in one bit only
  function automatic ptr_t bin_to_gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the xor of all Gray bits at and above it
  // so the chain runs from the top bit downwards
  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    bin[`FIFO_ADDR_SIZE] = gray[`FIFO_ADDR_SIZE];
    for (int i = `FIFO_ADDR_SIZE - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== tb.f ====
+incdir+.
fifo_ptr_pkg.sv
fifo_data_pkg.sv
cdc_sync2.sv
cdc_fifo_mem.sv
cdc_fifo_wptr_full.sv
cdc_fifo_rptr_empty.sv
cdc_fifo.sv
tb_cdc_fifo.sv

// ==== tb_cdc_fifo.sv ====
`timescale 1ns/1ps
`include "fifo_defs.svh"

module tb_cdc_fifo;

  // number of words the FIFO holds
  localparam int depth = 1 << `FIFO_ADDR_SIZE;

  // edges a flag gets to react before a wait gives up
  localparam int wait_limit = 50;

  // words pushed through the concurrent test and the cycle budget of each side
  localparam int stream_words = 400;
  localparam int stream_limit = 20000;

  // write domain
  logic                      w_clk;
  logic                      w_rst_n;
  logic                      w_inc;
  fifo_data_pkg::data_t      w_data;
  fifo_data_pkg::w_status_t  w_status;

  // read domain
  logic                      r_clk;
  logic                      r_rst_n;
  logic                      r_inc;
  fifo_data_pkg::data_t      r_data;
  fifo_data_pkg::r_status_t  r_status;

  // reference model, the head word sits at index zero
  fifo_data_pkg::data_t model[$];

  // separate random streams so each domain does not depend on the other's timing
  logic [31:0] rng_w;
  logic [31:0] rng_r;

  cdc_fifo dut (
    .w_clk    (w_clk),
    .w_rst_n  (w_rst_n),
    .w_inc    (w_inc),
    .w_data   (w_data),
    .w_status (w_status),
    .r_clk    (r_clk),
    .r_rst_n  (r_rst_n),
    .r_inc    (r_inc),
    .r_data   (r_data),
    .r_status (r_status)
  );

  // 20 ns write clock
  initial begin
    w_clk = 1'b0;
    forever #10 w_clk = ~w_clk;
  end

  // 34 ns read clock, its rising edges never coincide with an edge of the write clock
  initial begin
    r_clk = 1'b0;
    forever #17 r_clk = ~r_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string reason);
    $display("STATUS: FAIL");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
      abort_run("a checked value did not match its expected value");
    end
  endtask

  // one write strobe lasting a single w_clk cycle
  // full is looked at between the edges, where it holds the value the DUT uses
  // the task returns at the falling edge after the write edge, with the new flags settled
  task automatic write_one(input fifo_data_pkg::data_t d, output logic accepted);
    @(posedge w_clk);
    w_inc  <= 1'b1;
    w_data <= d;
    @(negedge w_clk);
    accepted = ~w_status.full;
    if (accepted) begin
      model.push_back(d);
    end
    @(posedge w_clk);
    w_inc <= 1'b0;
    @(negedge w_clk);
  endtask

  // one read strobe, the head word on r_data is compared before it is consumed
  task automatic read_one(output logic taken);
    @(posedge r_clk);
    r_inc <= 1'b1;
    @(negedge r_clk);
    taken = ~r_status.empty;
    if (taken) begin
      check_equal(32'(model.size() > 0), 32'd1, "read side shows a word the model lacks");
      check_equal(32'(r_data), 32'(model[0]), "head word on r_data");
      void'(model.pop_front());
    end
    @(posedge r_clk);
    r_inc <= 1'b0;
    @(negedge r_clk);
  endtask

  // the crossing delay varies, so empty is polled until it falls
  task automatic wait_not_empty();
    int n;
    n = 0;
    @(negedge r_clk);
    while (r_status.empty && n < wait_limit) begin
      @(negedge r_clk);
      n++;
    end
    if (r_status.empty) begin
      abort_run("timed out waiting for empty to fall after a write");
    end
  endtask

  task automatic check_reset_flags();
    @(negedge w_clk);
    check_equal(32'(w_status.full), 32'd0, "full after reset");
    check_equal(32'(w_status.almost_full), 32'd0, "almost_full after reset");
    @(negedge r_clk);
    check_equal(32'(r_status.empty), 32'd1, "empty after reset");
    check_equal(32'(r_status.almost_empty), 32'd1, "almost_empty after reset");
  endtask

  // fills an empty FIFO to the top, then tries one write too many
  task automatic fill_to_full();
    logic accepted;
    fifo_data_pkg::data_t d;
    // let the last read pointer cross so both flags start from a true count
    repeat (4) @(posedge w_clk);
    for (int i = 1; i <= depth; i++) begin
      rng_w = xorshift32(rng_w);
      d = fifo_data_pkg::data_t'(rng_w >> 8);
      write_one(d, accepted);
      check_equal(32'(accepted), 32'd1, "write into a FIFO with free space");
      check_equal(32'(w_status.full), 32'(i == depth), "full while filling");
      check_equal(32'(w_status.almost_full),
                  32'(i >= depth - `FIFO_ALMOST_FULL_BUF), "almost_full while filling");
    end
    // a stray write would land in the slot of the oldest word
    // so the extra word is its complement and the drain would show it
    d = ~model[0];
    write_one(d, accepted);
    check_equal(32'(accepted), 32'd0, "write strobe while full");
    check_equal(32'(model.size()), 32'(depth), "model size after write strobe while full");
    check_equal(32'(w_status.full), 32'd1, "full after write strobe while full");
  endtask

  // reads until the model is empty, with writes stopped
  task automatic drain_all();
    logic taken;
    wait_not_empty();
    // the write pointer needs a few more edges before the count is exact
    repeat (4) @(posedge r_clk);
    while (model.size() > 0) begin
      read_one(taken);
      check_equal(32'(taken), 32'd1, "read from a FIFO holding data");
      check_equal(32'(r_status.empty), 32'(model.size() == 0), "empty while draining");
      check_equal(32'(r_status.almost_empty),
                  32'(model.size() <= `FIFO_ALMOST_EMPTY_BUF), "almost_empty while draining");
    end
  endtask

  // a lone word must fall through to r_data once empty drops
  task automatic send_single_word();
    logic taken;
    fifo_data_pkg::data_t d;
    rng_w = xorshift32(rng_w);
    d = fifo_data_pkg::data_t'(rng_w >> 8);
    write_one(d, taken);
    check_equal(32'(taken), 32'd1, "single write into an empty FIFO");
    wait_not_empty();
    check_equal(32'(r_data), 32'(d), "single word on r_data");
    read_one(taken);
    check_equal(32'(taken), 32'd1, "read of the single word");
    check_equal(32'(r_status.empty), 32'd1, "empty after reading the single word");
  endtask

  // random write strobes and data, taken by the DUT only while full is low
  task automatic produce_words(input int count);
    int written;
    int cycles;
    written = 0;
    cycles = 0;
    while (written < count && cycles < stream_limit) begin
      @(posedge w_clk);
      rng_w = xorshift32(rng_w);
      w_inc  <= (rng_w[1:0] != 2'b00);
      w_data <= fifo_data_pkg::data_t'(rng_w >> 16);
      @(negedge w_clk);
      if (w_inc && !w_status.full) begin
        model.push_back(w_data);
        written++;
        check_equal(32'(model.size() <= depth), 32'd1, "model within depth");
      end
      cycles++;
    end
    @(posedge w_clk);
    w_inc <= 1'b0;
    if (written < count) begin
      abort_run("the writer ran out of cycles before all words were accepted");
    end
  endtask

  // random read strobes, each word taken is compared with the model head
  task automatic consume_words(input int count);
    int got;
    int cycles;
    got = 0;
    cycles = 0;
    while (got < count && cycles < stream_limit) begin
      @(posedge r_clk);
      rng_r = xorshift32(rng_r);
      r_inc <= (rng_r[2:0] < 3'd5);
      @(negedge r_clk);
      if (r_inc && !r_status.empty) begin
        check_equal(32'(model.size() > 0), 32'd1, "read side shows a word the model lacks");
        check_equal(32'(r_data), 32'(model[0]), "word read during concurrent traffic");
        void'(model.pop_front());
        got++;
      end
      cycles++;
    end
    @(posedge r_clk);
    r_inc <= 1'b0;
    if (got < count) begin
      abort_run("the reader ran out of cycles before all words came out");
    end
  endtask

  task automatic run_concurrent(input int count);
    fork
      produce_words(count);
      consume_words(count);
    join
    check_equal(32'(model.size()), 32'd0, "model empty after concurrent traffic");
  endtask

  // strobes that must be ignored, then traffic that must stay in step
  task automatic strobe_at_limits();
    logic taken;
    fifo_data_pkg::data_t d;
    read_one(taken);
    check_equal(32'(taken), 32'd0, "read strobe while empty");
    check_equal(32'(model.size()), 32'd0, "model after read strobe while empty");
    check_equal(32'(r_status.empty), 32'd1, "empty after read strobe while empty");
    fill_to_full();
    drain_all();
    for (int i = 0; i < 3; i++) begin
      rng_w = xorshift32(rng_w);
      d = fifo_data_pkg::data_t'(rng_w >> 8);
      write_one(d, taken);
      check_equal(32'(taken), 32'd1, "write after the limit strobes");
    end
    drain_all();
  endtask

  initial begin
    w_rst_n <= 1'b0;
    r_rst_n <= 1'b0;
    w_inc   <= 1'b0;
    w_data  <= '0;
    r_inc   <= 1'b0;
    rng_w = 32'd54363;
    rng_r = xorshift32(32'd54363);
    // each reset is held for four edges of its own clock
    fork
      begin
        repeat (4) @(posedge w_clk);
        w_rst_n <= 1'b1;
      end
      begin
        repeat (4) @(posedge r_clk);
        r_rst_n <= 1'b1;
      end
    join
    check_reset_flags();
    fill_to_full();
    drain_all();
    send_single_word();
    run_concurrent(stream_words);
    strobe_at_limits();
    $display("STATUS: PASS");
    $finish;
  end

endmodule
